// File: Makefile
# Verilator flow for the rate limiter
VERILATOR  ?= verilator
FILELIST   ?= rate_limiter.f
TB_TOP     ?= tb_rate_limiter
RTL_TOP    ?= rate_limiter
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= -j 0
LINT_FLAGS ?=
SOURCES    := $(wildcard logic/*.sv bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# The log decides pass or fail
sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_rate_limiter.sv
/* Directed testbench for the rate limiter with LFSR payloads,
   an expected beat queue and a rate bound monitor */
`timescale 1ns/1ps
`default_nettype none

module tb_rate_limiter;
  import rl_pkg::*;

  localparam int MAX_BEATS   = 6;
  localparam int LIMIT_RATE  = 1;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  logic                  axi_aclk = 1'b0;
  logic                  arst_n;
  logic [DATA_W-1:0]     s_axis_tdata;
  logic                  s_axis_tlast;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic [DATA_W-1:0]     m_axis_tdata;
  logic                  m_axis_tlast;
  logic                  m_axis_tvalid;
  logic                  m_axis_tready;
  logic                  reg_wr_en;
  logic                  reg_rd_en;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [REG_W-1:0]      reg_wdata;
  logic [REG_W-1:0]      reg_rdata;
  logic                  reg_rd_valid;

  logic [31:0]       data_lfsr;
  int                ready_mode;
  logic [DATA_W-1:0] exp_data[$];
  logic              exp_last[$];
  int                cycle_cnt = 0;
  int                bytes_sent = 0;
  int                beats_out = 0;
  int                mon_errs = 0;
  logic              rate_check;
  int                rate_cycle0;
  int                rate_bytes0;
  int                val_errs;
  int                timeouts;

  rate_limiter DUT (.*);

  always #20 axi_aclk = ~axi_aclk;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[DATA_W-2:0], data_lfsr[0]};
    end
  endtask

  // Output ready: 0 low, 1 high, else random from its own LFSR
  initial begin
    logic [31:0] rdy_lfsr;
    rdy_lfsr = 32'd83153;
    m_axis_tready = 1'b0;
    forever begin
      @(posedge axi_aclk);
      #2;
      if (ready_mode == 0) begin
        m_axis_tready = 1'b0;
      end else if (ready_mode == 1) begin
        m_axis_tready = 1'b1;
      end else begin
        rdy_lfsr = lfsr_next(rdy_lfsr);
        m_axis_tready = rdy_lfsr[0];
      end
    end
  end

  // Output monitor, sampled mid-cycle ahead of the transfer edge
  always @(negedge axi_aclk) begin
    if (arst_n) begin
      cycle_cnt++;
      if (m_axis_tvalid && m_axis_tready) begin
        bytes_sent += BEAT_BYTES;
        beats_out++;
        if (exp_data.size() == 0) begin
          $display("Unexpected output beat %h at %t with nothing left to send", m_axis_tdata,
                   $time);
          mon_errs++;
        end else begin
          assert (m_axis_tdata == exp_data[0] && m_axis_tlast == exp_last[0]) else begin
            $display("Error %t: output beat %h last %b, expected %h last %b", $time,
                     m_axis_tdata, m_axis_tlast, exp_data[0], exp_last[0]);
            mon_errs++;
          end
          void'(exp_data.pop_front());
          void'(exp_last.pop_front());
        end
      end
      if (rate_check) begin
        assert (bytes_sent - rate_bytes0 <=
                (cycle_cnt - rate_cycle0) * LIMIT_RATE + MAX_BEATS * BEAT_BYTES) else begin
          $display("Error %t: %0d bytes in %0d cycles is over the rate bound", $time,
                   bytes_sent - rate_bytes0, cycle_cnt - rate_cycle0);
          mon_errs++;
        end
      end
    end
  end

  task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
    @(posedge axi_aclk);
    #2;
    reg_wr_en = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(posedge axi_aclk);
    #2;
    reg_wr_en = 1'b0;
  endtask

  task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input logic [REG_W-1:0] expected,
                           input string what);
    int cnt;
    @(posedge axi_aclk);
    #2;
    reg_rd_en = 1'b1;
    reg_addr  = addr;
    @(posedge axi_aclk);
    #2;
    reg_rd_en = 1'b0;
    cnt = 0;
    @(negedge axi_aclk);
    while (!reg_rd_valid && cnt < WAIT_LIMIT) begin
      @(negedge axi_aclk);
      cnt++;
    end
    if (!reg_rd_valid) begin
      $display("Timeout waiting for read data of the %s register", what);
      timeouts++;
    end else begin
      assert (reg_rdata == expected) else begin
        $display("Error %t: %s read %h, expected %h", $time, what, reg_rdata, expected);
        val_errs++;
      end
    end
  endtask

  // One packet of 1 to 6 random beats, queued as expected when accepted
  task automatic send_packet();
    logic [DATA_W-1:0] v;
    int len;
    int cnt;
    take_bits(3, v);
    len = int'(v % 64'(MAX_BEATS)) + 1;
    @(posedge axi_aclk);
    #2;
    for (int i = 0; i < len; i++) begin
      take_bits(DATA_W, v);
      s_axis_tdata  = v;
      s_axis_tlast  = (i == len - 1);
      s_axis_tvalid = 1'b1;
      cnt = 0;
      @(negedge axi_aclk);
      while (!s_axis_tready && cnt < WAIT_LIMIT) begin
        @(negedge axi_aclk);
        cnt++;
      end
      if (s_axis_tready) begin
        exp_data.push_back(v);
        exp_last.push_back(s_axis_tlast);
      end else begin
        $display("Timeout: input beat never accepted, s_axis_tready stayed low");
        timeouts++;
      end
      @(posedge axi_aclk);
      #2;
    end
    s_axis_tvalid = 1'b0;
  endtask

  task automatic wait_drain(input string what);
    int cnt;
    cnt = 0;
    while (exp_data.size() != 0 && cnt < DRAIN_LIMIT) begin
      @(posedge axi_aclk);
      cnt++;
    end
    if (exp_data.size() != 0) begin
      $display("Timeout: %0d beats never left the DUT during %s", exp_data.size(), what);
      timeouts++;
    end
  endtask

  task automatic register_access();
    write_reg(ADDR_CTRL, 32'h2);
    check_reg(ADDR_CTRL, 32'h2, "control");
    write_reg(ADDR_RATE, 32'h0000_0A5C);
    check_reg(ADDR_RATE, 32'h0000_0A5C, "rate");
    check_reg(2'd3, 32'h0, "unused");
    write_reg(ADDR_CTRL, 32'h0);
    repeat (2) @(posedge axi_aclk);
    check_reg(ADDR_CREDIT, REG_W'(BUCKET_MAX), "credit");
  endtask

  task automatic bypass_traffic();
    write_reg(ADDR_CTRL, 32'h0);
    ready_mode = 2;
    repeat (8) send_packet();
    wait_drain("bypass");
  endtask

  // Soft reset first so the bucket starts empty
  task automatic rate_limiting();
    ready_mode = 1;
    write_reg(ADDR_RATE, REG_W'(LIMIT_RATE));
    write_reg(ADDR_CTRL, 32'h1);
    write_reg(ADDR_CTRL, 32'h2);
    rate_cycle0 = cycle_cnt;
    rate_bytes0 = bytes_sent;
    rate_check  = 1'b1;
    while (cycle_cnt - rate_cycle0 < 800) begin
      send_packet();
    end
    wait_drain("rate limiting");
    rate_check = 1'b0;
  endtask

  task automatic soft_reset_flush();
    ready_mode = 0;
    send_packet();
    write_reg(ADDR_CTRL, 32'h3);
    @(negedge axi_aclk);
    assert (!s_axis_tready && !m_axis_tvalid) else begin
      $display("Error %t: s_axis_tready %b m_axis_tvalid %b under soft reset", $time,
               s_axis_tready, m_axis_tvalid);
      val_errs++;
    end
    check_reg(ADDR_CREDIT, 32'h0, "credit");
    // Flushed beats must never show up
    exp_data.delete();
    exp_last.delete();
    write_reg(ADDR_RATE, REG_W'(BUCKET_MAX));
    write_reg(ADDR_CTRL, 32'h2);
    ready_mode = 2;
    repeat (3) send_packet();
    wait_drain("soft reset");
  endtask

  task automatic output_backpressure();
    logic [DATA_W-1:0] v;
    logic [DATA_W-1:0] held_data;
    logic              held_last;
    logic              stalled;
    int                accepted;
    ready_mode = 0;
    stalled    = 1'b0;
    accepted   = 0;
    @(posedge axi_aclk);
    #2;
    while (!stalled && accepted < FIFO_DEPTH + 4) begin
      take_bits(DATA_W, v);
      s_axis_tdata  = v;
      s_axis_tlast  = (accepted % 4 == 3);
      s_axis_tvalid = 1'b1;
      @(negedge axi_aclk);
      if (s_axis_tready) begin
        exp_data.push_back(v);
        exp_last.push_back(s_axis_tlast);
        accepted++;
      end else begin
        stalled = 1'b1;
      end
      @(posedge axi_aclk);
      #2;
    end
    s_axis_tvalid = 1'b0;
    assert (stalled && accepted <= FIFO_DEPTH + 1) else begin
      $display("Error %t: %0d beats accepted, s_axis_tready fell %b", $time, accepted, stalled);
      val_errs++;
    end
    @(negedge axi_aclk);
    held_data = m_axis_tdata;
    held_last = m_axis_tlast;
    repeat (6) begin
      @(negedge axi_aclk);
      assert (m_axis_tvalid && m_axis_tdata == held_data && m_axis_tlast == held_last) else begin
        $display("Error %t: stalled output moved to %h valid %b", $time, m_axis_tdata,
                 m_axis_tvalid);
        val_errs++;
      end
    end
    ready_mode = 1;
    wait_drain("back-pressure");
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    arst_n        = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tvalid = 1'b0;
    reg_wr_en     = 1'b0;
    reg_rd_en     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    data_lfsr     = 32'd83153;
    ready_mode    = 1;
    rate_check    = 1'b0;
    rate_cycle0   = 0;
    rate_bytes0   = 0;
    val_errs      = 0;
    timeouts      = 0;
    repeat (4) @(posedge axi_aclk);
    #2;
    arst_n = 1'b1;
    register_access();
    bypass_traffic();
    rate_limiting();
    soft_reset_flush();
    output_backpressure();
    repeat (4) @(posedge axi_aclk);
    $display("Beats out: %0d, value errors: %0d, timeouts: %0d", beats_out,
             val_errs + mon_errs, timeouts);
    if (val_errs + mon_errs + timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Last line of defence against a stuck run
  initial begin
    #(20000 * 40);
    $display("Simulation ran past its time limit");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/beat_fifo.sv
/* Beat FIFO for data and last, flushed by soft reset */
`timescale 1ns/1ps
`default_nettype none

module beat_fifo (
  input  wire                      axi_aclk,
  input  wire                      arst_n,
  input  wire                      sw_rst,
  input  wire [rl_pkg::DATA_W-1:0] in_data,
  input  wire                      in_last,
  input  wire                      in_valid,
  output logic                     in_ready,
  beat_if.source                   head
);
  import rl_pkg::*;

  logic [DATA_W-1:0]     mem_data [FIFO_DEPTH];
  logic                  mem_last [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr;
  logic [FIFO_PTR_W-1:0] rd_ptr;
  logic [FIFO_CNT_W-1:0] count;
  logic                  full;
  logic                  wr_en;
  logic                  rd_en;

  assign full     = (count == FIFO_CNT_W'(FIFO_DEPTH));
  assign in_ready = !full && !sw_rst;
  assign wr_en    = in_valid && in_ready;
  assign rd_en    = head.valid && head.ready;

  // Head of queue
  assign head.valid = (count != '0);
  assign head.data  = mem_data[rd_ptr];
  assign head.last  = mem_last[rd_ptr];

  // Payload storage
  always_ff @(posedge axi_aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr] <= in_data;
      mem_last[wr_ptr] <= in_last;
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (sw_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + FIFO_CNT_W'(1);
        2'b01:   count <= count - FIFO_CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  a_no_write_full : assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    full |-> !wr_en
  );

  a_count_bound : assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    count <= FIFO_CNT_W'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

// File: logic/beat_if.sv
/* Stream beat interface with source and sink modports */
`timescale 1ns/1ps
`default_nettype none

interface beat_if;
  import rl_pkg::*;

  logic [DATA_W-1:0] data;
  logic              last;
  logic              valid;
  logic              ready;

  // Beat producer side
  modport source (
    output data,
    output last,
    output valid,
    input  ready
  );

  // Beat consumer side
  modport sink (
    input  data,
    input  last,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

// File: logic/credit_bucket.sv
/* Signed credit accumulator with refill, saturation and per-beat charge */
`timescale 1ns/1ps
`default_nettype none

module credit_bucket (
  input  wire                               axi_aclk,
  input  wire                               arst_n,
  input  wire                               sw_rst,
  input  wire                               enable,
  input  wire        [rl_pkg::REG_W-1:0]    rate,
  input  wire                               beat_sent,
  output logic signed [rl_pkg::CREDIT_W-1:0] credit
);
  import rl_pkg::*;

  logic signed [CREDIT_W-1:0] refill;
  logic signed [CREDIT_W-1:0] credit_nxt;

  always_comb begin
    // A rate of a full bucket or more tops it up in one clock
    if (rate >= REG_W'(BUCKET_MAX)) begin
      refill = CREDIT_W'(BUCKET_MAX);
    end else begin
      refill = credit + $signed({1'b0, rate[CREDIT_W-2:0]});
      if (refill > CREDIT_W'(BUCKET_MAX)) begin
        refill = CREDIT_W'(BUCKET_MAX);
      end
    end
    // Charge goes after the clamp, so credit may dip below zero mid-packet
    if (beat_sent) begin
      credit_nxt = refill - CREDIT_W'(BEAT_BYTES);
    end else begin
      credit_nxt = refill;
    end
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      credit <= '0;
    end else if (sw_rst) begin
      credit <= '0;
    end else if (!enable) begin
      // Full bucket while bypassed
      credit <= CREDIT_W'(BUCKET_MAX);
    end else begin
      credit <= credit_nxt;
    end
  end

  a_credit_max : assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    credit <= CREDIT_W'(BUCKET_MAX)
  );

endmodule

`default_nettype wire

// File: logic/egress_gate.sv
/* Packet start gating from FIFO head and credit state */
`timescale 1ns/1ps
`default_nettype none

module egress_gate (
  input  wire                               axi_aclk,
  input  wire                               arst_n,
  input  wire                               sw_rst,
  input  wire                               enable,
  input  wire signed [rl_pkg::CREDIT_W-1:0] credit,
  beat_if.sink                              head,
  output logic       [rl_pkg::DATA_W-1:0]   m_data,
  output logic                              m_last,
  output logic                              m_valid,
  input  wire                               m_ready,
  output logic                              beat_sent
);
  import rl_pkg::*;

  logic in_pkt;
  logic permit;

  // A started packet is never cut, a new one waits for credit >= 0
  assign permit = in_pkt || !enable || !credit[CREDIT_W-1];

  assign m_valid    = head.valid && permit && !sw_rst;
  assign head.ready = m_ready && permit && !sw_rst;
  assign m_data     = head.data;
  assign m_last     = head.last;
  assign beat_sent  = m_valid && m_ready;

  // Packet boundary tracking
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      in_pkt <= 1'b0;
    end else if (sw_rst) begin
      in_pkt <= 1'b0;
    end else if (beat_sent) begin
      in_pkt <= !m_last;
    end
  end

  // Stalled beat holds through FIFO, bucket and gate together
  a_stall_stable : assert property (
    @(posedge axi_aclk) disable iff (!arst_n || sw_rst)
    m_valid && !m_ready |=> m_valid && $stable(m_data) && $stable(m_last)
  );

endmodule

`default_nettype wire

// File: logic/rate_ctrl_regs.sv
/* Control, rate and credit snapshot registers with plain
   write and read strobes */
`timescale 1ns/1ps
`default_nettype none

module rate_ctrl_regs (
  input  wire                                axi_aclk,
  input  wire                                arst_n,
  input  wire                                reg_wr_en,
  input  wire                                reg_rd_en,
  input  wire        [rl_pkg::REG_ADDR_W-1:0] reg_addr,
  input  wire        [rl_pkg::REG_W-1:0]      reg_wdata,
  input  wire signed [rl_pkg::CREDIT_W-1:0]   credit,
  output logic       [rl_pkg::REG_W-1:0]      reg_rdata,
  output logic                               reg_rd_valid,
  output logic                               enable,
  output logic                               sw_rst,
  output logic       [rl_pkg::REG_W-1:0]      rate
);
  import rl_pkg::*;

  reg_word_u        wr_word;
  ctrl_fields_t     ctrl_q;
  logic [REG_W-1:0] rd_word;

  assign wr_word = reg_wdata;
  assign enable  = ctrl_q.enable;
  assign sw_rst  = ctrl_q.sw_rst;

  // Register writes
  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_q <= '0;
      rate   <= '0;
    end else if (reg_wr_en) begin
      case (reg_addr)
        ADDR_CTRL: begin
          ctrl_q.sw_rst <= wr_word.ctrl.sw_rst;
          ctrl_q.enable <= wr_word.ctrl.enable;
        end
        ADDR_RATE: begin
          rate <= wr_word.rate;
        end
        default: begin
        end
      endcase
    end
  end

  // Read mux, credit is sign extended
  always_comb begin
    case (reg_addr)
      ADDR_CTRL:   rd_word = ctrl_q;
      ADDR_RATE:   rd_word = rate;
      ADDR_CREDIT: rd_word = {{(REG_W - CREDIT_W){credit[CREDIT_W-1]}}, credit};
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge axi_aclk or negedge arst_n) begin
    if (!arst_n) begin
      reg_rd_valid <= 1'b0;
    end else begin
      reg_rd_valid <= reg_rd_en;
    end
  end

  // Read data capture
  always_ff @(posedge axi_aclk) begin
    if (reg_rd_en) begin
      reg_rdata <= rd_word;
    end
  end

  // Each valid pulse in a run comes from its own read request
  a_rd_valid_per_req : assert property (
    @(posedge axi_aclk) disable iff (!arst_n)
    reg_rd_valid && $past(reg_rd_valid) |-> $past(reg_rd_en) && $past(reg_rd_en, 2)
  );

endmodule

`default_nettype wire

// File: logic/rate_limiter.sv
/* Single queue packet rate limiter top level */
`timescale 1ns/1ps
`default_nettype none

module rate_limiter (
  input  wire                          axi_aclk,
  input  wire                          arst_n,

  // Input stream
  input  wire [rl_pkg::DATA_W-1:0]     s_axis_tdata,
  input  wire                          s_axis_tlast,
  input  wire                          s_axis_tvalid,
  output logic                         s_axis_tready,

  // Output stream
  output logic [rl_pkg::DATA_W-1:0]    m_axis_tdata,
  output logic                         m_axis_tlast,
  output logic                         m_axis_tvalid,
  input  wire                          m_axis_tready,

  // Register access
  input  wire                          reg_wr_en,
  input  wire                          reg_rd_en,
  input  wire [rl_pkg::REG_ADDR_W-1:0] reg_addr,
  input  wire [rl_pkg::REG_W-1:0]      reg_wdata,
  output logic [rl_pkg::REG_W-1:0]     reg_rdata,
  output logic                         reg_rd_valid
);
  import rl_pkg::*;

  logic                       enable;
  logic                       sw_rst;
  logic [REG_W-1:0]           rate;
  logic signed [CREDIT_W-1:0] credit;
  logic                       beat_sent;

  beat_if head_if ();

  rate_ctrl_regs regs_inst (
    .axi_aclk     (axi_aclk),
    .arst_n       (arst_n),
    .reg_wr_en    (reg_wr_en),
    .reg_rd_en    (reg_rd_en),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .credit       (credit),
    .reg_rdata    (reg_rdata),
    .reg_rd_valid (reg_rd_valid),
    .enable       (enable),
    .sw_rst       (sw_rst),
    .rate         (rate)
  );

  beat_fifo fifo_inst (
    .axi_aclk (axi_aclk),
    .arst_n   (arst_n),
    .sw_rst   (sw_rst),
    .in_data  (s_axis_tdata),
    .in_last  (s_axis_tlast),
    .in_valid (s_axis_tvalid),
    .in_ready (s_axis_tready),
    .head     (head_if.source)
  );

  credit_bucket bucket_inst (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .sw_rst    (sw_rst),
    .enable    (enable),
    .rate      (rate),
    .beat_sent (beat_sent),
    .credit    (credit)
  );

  egress_gate gate_inst (
    .axi_aclk  (axi_aclk),
    .arst_n    (arst_n),
    .sw_rst    (sw_rst),
    .enable    (enable),
    .credit    (credit),
    .head      (head_if.sink),
    .m_data    (m_axis_tdata),
    .m_last    (m_axis_tlast),
    .m_valid   (m_axis_tvalid),
    .m_ready   (m_axis_tready),
    .beat_sent (beat_sent)
  );

endmodule

`default_nettype wire

// File: logic/rl_pkg.sv
/* Stream widths, register map, credit bucket limits and the register
   write word types shared by the rate limiter */
`default_nettype none

package rl_pkg;

  // Stream beat
  localparam int DATA_W     = 64;
  localparam int BEAT_BYTES = 8;

  // Register map
  localparam int REG_W      = 32;
  localparam int REG_ADDR_W = 2;
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL   = 2'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_RATE   = 2'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_CREDIT = 2'd2;

  // Signed credit in bytes
  localparam int CREDIT_W   = 20;
  localparam int BUCKET_MAX = 4096;

  // Beat FIFO sizing
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

  // Control register layout
  typedef struct packed {
    logic [REG_W-3:0] rsvd;
    logic             enable;
    logic             sw_rst;
  } ctrl_fields_t;

  // Write word seen as control fields or as a raw rate
  typedef union packed {
    ctrl_fields_t     ctrl;
    logic [REG_W-1:0] rate;
  } reg_word_u;

endpackage

`default_nettype wire

// File: rate_limiter.f
logic/rl_pkg.sv
logic/beat_if.sv
logic/rate_ctrl_regs.sv
logic/beat_fifo.sv
logic/credit_bucket.sv
logic/egress_gate.sv
logic/rate_limiter.sv
bench/tb_rate_limiter.sv
